//--- cache_settings.svh
/*
  Instruction cache sizing
  Address split, bus widths, geometry and the bus read tag code
*/
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Fetch port
`define ADDRESS_SIZE      32
`define INSTRUCTION_SIZE  32

// Memory bus
`define BUS_DATA_WIDTH    64
`define BUS_TAG_WIDTH     13

// Geometry: 4 ways x 8 sets x 64 byte lines
`define WAYS              4
`define SETS              8
`define CELLS_NEEDED      8

// Address split, tag + index + offset = ADDRESS_SIZE
`define OFFSET_SIZE_B     6
`define INDEX_SIZE_B      3
`define TAG_SIZE_B        23

// Tag code of a line read on the bus
`define MEM_READ          13'h0501

`endif

//--- cache_pkg.sv
/*
  Instruction cache types
  Address split, line payload, fill commit and lookup result
*/
`include "cache_settings.svh"

package cache_pkg;

  // Fetch address as seen by the cache
  typedef struct packed {
    logic [`TAG_SIZE_B-1:0]    tag;
    logic [`INDEX_SIZE_B-1:0]  index;
    logic [`OFFSET_SIZE_B-1:0] offset;
  } cache_address_t;

  // One line, cell 0 at the lowest address
  typedef struct packed {
    logic [`CELLS_NEEDED-1:0][`BUS_DATA_WIDTH-1:0] cells;
  } cache_line_t;

  // Commit of a filled line into one way of one set
  typedef struct packed {
    logic [$clog2(`WAYS)-1:0] way;
    logic [`INDEX_SIZE_B-1:0] index;
    logic [`TAG_SIZE_B-1:0]   tag;
    cache_line_t              line;
  } line_write_t;

  // Outcome of a tag compare for the requested set
  typedef struct packed {
    logic                     hit;
    logic [$clog2(`WAYS)-1:0] hit_way;
    logic [$clog2(`WAYS)-1:0] victim_way;
  } lookup_result_t;

endpackage

//--- cache_lookup.sv
/*
  Tag store of the instruction cache
  Four-way compare at the requested set, round-robin victim per set
*/
`timescale 1ns/10ps
`include "cache_settings.svh"

module cache_lookup
  import cache_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  cache_address_t req_addr,
  input  line_write_t    line_write,
  input  logic           line_write_en,
  output lookup_result_t result
);

  // Tags carry no reset, valid bits guard them
  logic [`TAG_SIZE_B-1:0] tags [`WAYS][`SETS];
  logic [`WAYS-1:0][`SETS-1:0] valid;

  // Next way to replace in each set
  logic [`SETS-1:0][$clog2(`WAYS)-1:0] rr_ptr;

  // Tag and valid update on a commit
  always_ff @(posedge clk) begin
    if (!reset) begin
      valid <= '0;
    end else if (line_write_en) begin
      valid[line_write.way][line_write.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (line_write_en) begin
      tags[line_write.way][line_write.index] <= line_write.tag;
    end
  end

  // Pointer moves on every commit to its set, wraps after the last way
  always_ff @(posedge clk) begin
    if (!reset) begin
      rr_ptr <= '0;
    end else if (line_write_en) begin
      rr_ptr[line_write.index] <= rr_ptr[line_write.index] + 1'b1;
    end
  end

  // Compare all ways in parallel
  // At most one way can match, tags within a set are unique
  always_comb begin
    result.hit = 1'b0;
    result.hit_way = '0;
    for (int w = 0; w < `WAYS; w++) begin
      if (valid[w][req_addr.index] && tags[w][req_addr.index] == req_addr.tag) begin
        result.hit = 1'b1;
        result.hit_way = w[$clog2(`WAYS)-1:0];
      end
    end
    result.victim_way = rr_ptr[req_addr.index];
  end

endmodule

//--- cache_data_array.sv
/*
  Line storage of the instruction cache
  Whole-line writes on a commit, 32-bit word select on the hit way
*/
`timescale 1ns/10ps
`include "cache_settings.svh"

module cache_data_array
  import cache_pkg::*;
(
  input  logic                          clk,
  input  cache_address_t                req_addr,
  input  logic [$clog2(`WAYS)-1:0]      hit_way,
  input  line_write_t                   line_write,
  input  logic                          line_write_en,
  output logic [`INSTRUCTION_SIZE-1:0]  hit_word
);

  // One line per way and set
  cache_line_t lines [`WAYS][`SETS];

  // Selected line and cell of the current request
  cache_line_t                 sel_line;
  logic [`BUS_DATA_WIDTH-1:0]  sel_cell;

  // Fill commit writes all eight cells at once
  always_ff @(posedge clk) begin
    if (line_write_en) begin
      lines[line_write.way][line_write.index] <= line_write.line;
    end
  end

  // Offset bits 5:3 pick the cell, bit 2 the half
  // Lower address word sits in the low half of a cell
  always_comb begin
    sel_line = lines[hit_way][req_addr.index];
    sel_cell = sel_line.cells[req_addr.offset[`OFFSET_SIZE_B-1:3]];
    if (req_addr.offset[2]) begin
      hit_word = sel_cell[`BUS_DATA_WIDTH-1:`INSTRUCTION_SIZE];
    end else begin
      hit_word = sel_cell[`INSTRUCTION_SIZE-1:0];
    end
  end

endmodule

//--- cache_line_fill.sv
/*
  Line fill bus master
  Sends one line read, collects eight response beats into a line
*/
`timescale 1ns/10ps
`include "cache_settings.svh"

module cache_line_fill
  import cache_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        fill_start,
  input  cache_address_t              line_addr,
  output logic                        fill_done,
  output cache_line_t                 fill_line,
  // Request channel
  output logic                        bus_reqcyc,
  input  logic                        bus_reqack,
  output logic [`BUS_DATA_WIDTH-1:0]  bus_req,
  output logic [`BUS_TAG_WIDTH-1:0]   bus_reqtag,
  // Response channel
  input  logic                        bus_respcyc,
  output logic                        bus_respack,
  input  logic [`BUS_DATA_WIDTH-1:0]  bus_resp,
  input  logic [`BUS_TAG_WIDTH-1:0]   bus_resptag
);

  logic [$clog2(`CELLS_NEEDED)-1:0] beat_cnt;
  logic                             beat_ok;

  // Accepted beat that belongs to our read
  assign beat_ok = bus_respcyc && bus_respack && bus_resptag == `MEM_READ;

  // Request and collect control
  always_ff @(posedge clk) begin
    if (!reset) begin
      bus_reqcyc  <= 1'b0;
      bus_respack <= 1'b0;
      fill_done   <= 1'b0;
      beat_cnt    <= '0;
    end else begin
      fill_done <= 1'b0;
      if (fill_start) begin
        bus_reqcyc <= 1'b1;
      end else if (bus_reqcyc && bus_reqack) begin
        // Request taken, start collecting
        bus_reqcyc  <= 1'b0;
        bus_respack <= 1'b1;
        beat_cnt    <= '0;
      end else if (beat_ok) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (beat_cnt == $clog2(`CELLS_NEEDED)'(`CELLS_NEEDED - 1)) begin
          bus_respack <= 1'b0;
          fill_done   <= 1'b1;
        end
      end
    end
  end

  // Line address with offset cleared, zero-extended to bus width
  always_ff @(posedge clk) begin
    if (fill_start) begin
      bus_req <= {{(`BUS_DATA_WIDTH - `ADDRESS_SIZE){1'b0}},
                  line_addr.tag, line_addr.index, {`OFFSET_SIZE_B{1'b0}}};
      bus_reqtag <= `MEM_READ;
    end
  end

  // Beats land in ascending cell order
  // Line holds until the next fill overwrites it
  always_ff @(posedge clk) begin
    if (beat_ok) begin
      fill_line.cells[beat_cnt] <= bus_resp;
    end
  end

endmodule

//--- cache_ctrl.sv
/*
  Fetch port controller
  Sequences lookup, line fill, array commit and the one-cycle response
*/
`timescale 1ns/10ps
`include "cache_settings.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          instruction_read,
  input  logic [`ADDRESS_SIZE-1:0]      instruction_address,
  output logic                          busy,
  output logic                          instruction_valid,
  output logic [`INSTRUCTION_SIZE-1:0]  instruction_response,
  output cache_address_t                req_addr,
  input  lookup_result_t                lookup,
  input  logic [`INSTRUCTION_SIZE-1:0]  hit_word,
  output logic                          fill_start,
  input  logic                          fill_done,
  input  cache_line_t                   fill_line,
  output line_write_t                   line_write,
  output logic                          line_write_en
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_LOOKUP, ST_FILL, ST_WRITE, ST_RESPOND
  } state_t;

  state_t                    state;
  logic [$clog2(`WAYS)-1:0]  victim_q;

  // Main FSM
  always_ff @(posedge clk) begin
    if (!reset) begin
      state             <= ST_IDLE;
      busy              <= 1'b0;
      instruction_valid <= 1'b0;
      fill_start        <= 1'b0;
    end else begin
      instruction_valid <= 1'b0;
      fill_start        <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (instruction_read) begin
            busy  <= 1'b1;
            state <= ST_LOOKUP;
          end
        end
        // Hit answers next cycle, miss kicks off the fill
        ST_LOOKUP: begin
          if (lookup.hit) begin
            state <= ST_RESPOND;
          end else begin
            fill_start <= 1'b1;
            state      <= ST_FILL;
          end
        end
        ST_FILL: begin
          if (fill_done) begin
            state <= ST_WRITE;
          end
        end
        // Commit, then look up again so data comes from the array
        ST_WRITE: state <= ST_LOOKUP;
        ST_RESPOND: begin
          instruction_valid <= 1'b1;
          busy              <= 1'b0;
          state             <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request address, held for the whole transaction
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && instruction_read) begin
      req_addr <= cache_address_t'(instruction_address);
    end
  end

  // Victim sampled when the line is complete
  always_ff @(posedge clk) begin
    if (state == ST_FILL && fill_done) begin
      victim_q <= lookup.victim_way;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_RESPOND) begin
      instruction_response <= hit_word;
    end
  end

  // Fill line stays stable in the line fill register
  assign line_write.way   = victim_q;
  assign line_write.index = req_addr.index;
  assign line_write.tag   = req_addr.tag;
  assign line_write.line  = fill_line;
  assign line_write_en    = state == ST_WRITE;

endmodule

//--- icache_top.sv
/*
  Four-way set-associative instruction cache
  Fetch port in front, tagged cyc/ack memory bus behind
*/
`timescale 1ns/10ps
`include "cache_settings.svh"

module icache_top
  import cache_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  // Memory read response
  input  logic                          bus_respcyc,
  output logic                          bus_respack,
  input  logic [`BUS_DATA_WIDTH-1:0]    bus_resp,
  input  logic [`BUS_TAG_WIDTH-1:0]     bus_resptag,
  // Memory request
  output logic                          bus_reqcyc,
  input  logic                          bus_reqack,
  output logic [`BUS_DATA_WIDTH-1:0]    bus_req,
  output logic [`BUS_TAG_WIDTH-1:0]     bus_reqtag,
  // Fetch port
  output logic                          busy,
  input  logic                          instruction_read,
  input  logic [`ADDRESS_SIZE-1:0]      instruction_address,
  output logic [`INSTRUCTION_SIZE-1:0]  instruction_response,
  output logic                          instruction_valid
);

  cache_address_t                 req_addr;
  lookup_result_t                 lookup;
  logic [`INSTRUCTION_SIZE-1:0]   hit_word;
  logic                           fill_start;
  logic                           fill_done;
  cache_line_t                    fill_line;
  line_write_t                    line_write;
  logic                           line_write_en;

  cache_ctrl ctrl0 (
    .clk, .reset, .instruction_read, .instruction_address,
    .busy, .instruction_valid, .instruction_response,
    .req_addr, .lookup, .hit_word,
    .fill_start, .fill_done, .fill_line,
    .line_write, .line_write_en
  );

  cache_lookup lookup0 (
    .clk, .reset, .req_addr, .line_write, .line_write_en,
    .result (lookup)
  );

  // Word select follows the hit way of the lookup
  cache_data_array data0 (
    .clk, .req_addr, .hit_way (lookup.hit_way),
    .line_write, .line_write_en, .hit_word
  );

  cache_line_fill fill0 (
    .clk, .reset, .fill_start, .line_addr (req_addr),
    .fill_done, .fill_line,
    .bus_reqcyc, .bus_reqack, .bus_req, .bus_reqtag,
    .bus_respcyc, .bus_respack, .bus_resp, .bus_resptag
  );

endmodule

//--- bus_mem_model.sv
/*
  Memory model for the cache bus
  Answers line reads with an address pattern after random delays
*/
`timescale 1ns/10ps
`include "cache_settings.svh"

module bus_mem_model #(
  parameter logic [31:0] SEED = 32'hf3c0_c0d1
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        bus_reqcyc,
  output logic                        bus_reqack,
  input  logic [`BUS_DATA_WIDTH-1:0]  bus_req,
  input  logic [`BUS_TAG_WIDTH-1:0]   bus_reqtag,
  output logic                        bus_respcyc,
  input  logic                        bus_respack,
  output logic [`BUS_DATA_WIDTH-1:0]  bus_resp,
  output logic [`BUS_TAG_WIDTH-1:0]   bus_resptag
);

  typedef enum logic [1:0] {MEM_IDLE, MEM_ACK, MEM_BEATS} mem_state_t;

  mem_state_t                state;
  logic [`ADDRESS_SIZE-1:0]  base;
  integer                    seed;
  int                        delay;
  int                        beat;
  int                        gap;

  // Each 32-bit word is a hash of its own byte address
  // Lower address sits in the low half of a cell
  function automatic logic [`BUS_DATA_WIDTH-1:0] cell_at(input logic [31:0] a);
    return {((a + 32'd4) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3,
            (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3};
  endfunction

  initial begin
    seed        = SEED;
    state       = MEM_IDLE;
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    bus_resptag = '0;
  end

  always @(posedge clk) begin
    if (!reset) begin
      state       <= MEM_IDLE;
      bus_reqack  <= 1'b0;
      bus_respcyc <= 1'b0;
    end else begin
      bus_reqack <= 1'b0;
      case (state)
        // Only line reads are served
        MEM_IDLE: begin
          if (bus_reqcyc && bus_reqtag == `MEM_READ) begin
            base  <= bus_req[`ADDRESS_SIZE-1:0];
            delay <= $unsigned($random(seed)) % 4;
            state <= MEM_ACK;
          end
        end
        // Acknowledge after 0 to 3 idle cycles
        MEM_ACK: begin
          if (delay == 0) begin
            bus_reqack <= 1'b1;
            beat       <= 0;
            delay      <= $unsigned($random(seed)) % 3;
            state      <= MEM_BEATS;
          end else begin
            delay <= delay - 1;
          end
        end
        MEM_BEATS: begin
          if (bus_respcyc && bus_respack) begin
            beat <= beat + 1;
            gap = $unsigned($random(seed)) % 3;
            if (beat == `CELLS_NEEDED - 1) begin
              bus_respcyc <= 1'b0;
              state       <= MEM_IDLE;
            end else if (gap == 0) begin
              // Back to back, next beat follows at once
              bus_resp <= cell_at(base + 32'(beat + 1) * 8);
            end else begin
              bus_respcyc <= 1'b0;
              delay       <= gap - 1;
            end
          end else if (!bus_respcyc) begin
            if (delay == 0) begin
              bus_respcyc <= 1'b1;
              bus_resp    <= cell_at(base + 32'(beat) * 8);
              bus_resptag <= `MEM_READ;
            end else begin
              delay <= delay - 1;
            end
          end
        end
        default: state <= MEM_IDLE;
      endcase
    end
  end

endmodule

//--- tb_icache.sv
/*
  Instruction cache testbench
  Directed and random fetches against a tag model, memory with random delays
*/
`timescale 1ns/10ps
`include "cache_settings.svh"

module tb_icache;

  logic                          clk;
  logic                          reset;
  logic                          instruction_read;
  logic [`ADDRESS_SIZE-1:0]      instruction_address;
  logic                          busy;
  logic                          instruction_valid;
  logic [`INSTRUCTION_SIZE-1:0]  instruction_response;
  logic                          bus_reqcyc;
  logic                          bus_reqack;
  logic [`BUS_DATA_WIDTH-1:0]    bus_req;
  logic [`BUS_TAG_WIDTH-1:0]     bus_reqtag;
  logic                          bus_respcyc;
  logic                          bus_respack;
  logic [`BUS_DATA_WIDTH-1:0]    bus_resp;
  logic [`BUS_TAG_WIDTH-1:0]     bus_resptag;

  // Reference tag state
  logic [`TAG_SIZE_B-1:0]    m_tag   [`WAYS][`SETS];
  bit                        m_valid [`WAYS][`SETS];
  logic [$clog2(`WAYS)-1:0]  m_rr    [`SETS];

  integer seed;
  int     misses;

  icache_top dut0 (.*);

  bus_mem_model #(.SEED(32'hf3c0_c0d1)) mem0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("FAILED %s: got %h, expected %h", name, got, expected);
      abort_run();
    end
  endtask

  // Word at a byte address, hash of the word-aligned address
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] word_addr;
    word_addr = {addr[31:2], 2'b00};
    return (word_addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  // Tag in set 5, word 4 of the line
  function automatic logic [`ADDRESS_SIZE-1:0] same_set_address(input int tag);
    return {tag[`TAG_SIZE_B-1:0], 3'd5, 6'h10};
  endfunction

  task automatic model_access(input logic [`ADDRESS_SIZE-1:0] addr, output bit hit);
    logic [`TAG_SIZE_B-1:0]    tag;
    logic [`INDEX_SIZE_B-1:0]  idx;
    tag = addr[`ADDRESS_SIZE-1 -: `TAG_SIZE_B];
    idx = addr[`OFFSET_SIZE_B +: `INDEX_SIZE_B];
    hit = 1'b0;
    for (int w = 0; w < `WAYS; w++) begin
      if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
        hit = 1'b1;
      end
    end
    // Miss refills the round-robin way, valid or not
    if (!hit) begin
      m_tag[m_rr[idx]][idx]   = tag;
      m_valid[m_rr[idx]][idx] = 1'b1;
      m_rr[idx]               = m_rr[idx] + 1'b1;
    end
  endtask

  // One fetch, returns the number of line requests seen
  task automatic fetch(input logic [`ADDRESS_SIZE-1:0] addr, output int reqs);
    int                        cycles;
    bit                        hit;
    logic [`ADDRESS_SIZE-1:0]  line_addr;
    model_access(addr, hit);
    line_addr = {addr[`ADDRESS_SIZE-1:`OFFSET_SIZE_B], {`OFFSET_SIZE_B{1'b0}}};
    instruction_read    <= 1'b1;
    instruction_address <= addr;
    // Accepted on the first edge with busy low
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > 20) begin
        $display("Timeout: fetch of %h was never accepted", addr);
        abort_run();
      end
    end while (busy);
    instruction_read <= 1'b0;
    cycles = 0;
    reqs   = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (bus_reqcyc && bus_reqack) begin
        reqs++;
        check_value("bus_req", bus_req,
                    {{(`BUS_DATA_WIDTH - `ADDRESS_SIZE){1'b0}}, line_addr});
        check_value("bus_reqtag", bus_reqtag, `MEM_READ);
      end
      if (cycles > 200) begin
        $display("Timeout: no instruction_valid for fetch of %h", addr);
        abort_run();
      end
    end while (!instruction_valid);
    check_value("instruction_response", instruction_response, expected_word(addr));
    check_value("busy", busy, 1'b0);
    check_value("bus request count", reqs, hit ? 0 : 1);
    if (hit) begin
      // Valid rose two edges after acceptance, seen one edge later
      check_value("instruction_valid latency", cycles - 1, 2);
    end else begin
      misses++;
    end
  endtask

  initial begin
    int                        reqs;
    int                        gap;
    logic [`ADDRESS_SIZE-1:0]  addr;
    int                        revisit_tag  [4];
    int                        revisit_reqs [4];
    seed                = 32'hf3c0_c0d1;
    revisit_tag         = '{2, 1, 3, 2};
    revisit_reqs        = '{0, 1, 0, 1};
    misses              = 0;
    reset               = 1'b0;
    instruction_read    = 1'b0;
    instruction_address = '0;
    for (int s = 0; s < `SETS; s++) begin
      m_rr[s] = '0;
      for (int w = 0; w < `WAYS; w++) begin
        m_valid[w][s] = 1'b0;
      end
    end
    repeat (16) @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);
    check_value("busy", busy, 1'b0);
    check_value("instruction_valid", instruction_valid, 1'b0);
    check_value("bus_reqcyc", bus_reqcyc, 1'b0);
    check_value("bus_respack", bus_respack, 1'b0);

    // Cold line, one request, then hits within the same line
    fetch(32'h0000_1048, reqs);
    check_value("bus request count", reqs, 1);
    fetch(32'h0000_1040, reqs);
    fetch(32'h0000_107c, reqs);
    fetch(32'h0000_1048, reqs);
    check_value("bus request count", reqs, 0);

    // Five tags in one set, way 0 goes first, then way 1
    for (int t = 1; t <= 5; t++) begin
      fetch(same_set_address(t), reqs);
      check_value("bus request count", reqs, 1);
    end
    for (int i = 0; i < 4; i++) begin
      fetch(same_set_address(revisit_tag[i]), reqs);
      check_value("bus request count", reqs, revisit_reqs[i]);
    end

    // Random fetches over 8 KB, 16 tags per set
    for (int n = 0; n < 400; n++) begin
      addr      = $unsigned($random(seed)) % 32'h2000;
      addr[1:0] = 2'b00;
      gap       = $unsigned($random(seed)) % 4;
      fetch(addr, reqs);
      repeat (gap) @(posedge clk);
    end

    $display("Line fills: %0d", misses);
    $display("all tests passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
cache_pkg.sv
cache_lookup.sv
cache_data_array.sv
cache_line_fill.sv
cache_ctrl.sv
icache_top.sv
bus_mem_model.sv
tb_icache.sv

//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - cache_lookup.sv
      - cache_data_array.sv
      - cache_line_fill.sv
      - cache_ctrl.sv
      - icache_top.sv
      - target: test
        files:
          - bus_mem_model.sv
          - tb_icache.sv
